//--- edge_thinning_tests.txt
// Columns (hex): input pixel, expected output byte, stall flag
// Two 6x4 frames in raster order, one pixel and its result per line
// Frame 0: flat gray, no gradient anywhere
80 00 0
80 00 0
80 00 0
80 00 1
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
80 00 1
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
80 00 1
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
80 00 0
// Frame 1: vertical step between columns 2 and 3, magnitude 60 kept in column 2
20 00 0
20 00 0
20 00 0
38 00 0
38 00 0
38 00 0
20 00 0
20 00 0
20 60 1
38 00 0
38 00 0
38 00 0
20 00 0
20 00 0
20 60 1
38 00 0
38 00 0
38 00 0
20 00 0
20 00 0
20 00 1
38 00 0
38 00 0
38 00 0

//--- sources.f
+incdir+.
image_pkg.sv
stream_pkg.sv
sobel_gradient.sv
gradient_buffer.sv
non_maximum_suppressor.sv
edge_thinning_top.sv
edge_thinning_tb.sv

//--- edge_thinning_tb.sv
// Testbench for the edge-thinning top level with file-driven pixels, output stalls and checks
`timescale 1ns/1ps
`include "edge_params.svh"

module edge_thinning_tb;

    localparam int PIXELS = `EDGE_WIDTH * `EDGE_HEIGHT;
    localparam int FRAMES = 2;
    localparam int TOTAL = PIXELS * FRAMES;
    localparam int WAIT_LIMIT = 500;
    localparam int DRAIN_CYCLES = 40;

    logic                  clock;
    logic                  reset;
    logic                  in_rd_en;
    logic                  in_empty;
    image_pkg::pixel_t     in_dout;
    logic                  out_wr_en;
    logic                  out_full;
    image_pkg::magnitude_t out_din;

    // Three words per file line for pixel, expected byte and stall flag
    logic [7:0] test_words [3*TOTAL];

    image_pkg::pixel_t     pixel_in [TOTAL];
    image_pkg::magnitude_t expected [TOTAL];
    logic                  stall_flag [TOTAL];
    int                    gap_len [TOTAL];
    int                    stall_len [TOTAL];

    integer seed;
    int     value_errors;
    int     count_errors;
    int     protocol_errors;
    int     timeouts;
    int     file_errors;
    int     write_count;

    always #20 clock = ~clock;

    edge_thinning_top i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (in_rd_en),
        .in_empty  (in_empty),
        .in_dout   (in_dout),
        .out_wr_en (out_wr_en),
        .out_full  (out_full),
        .out_din   (out_din)
    );

    // A write seen at the falling edge lands on the next rising edge
    always @(negedge clock) begin
        if (!reset && out_wr_en) begin
            write_count = write_count + 1;
            if (out_full) begin
                protocol_errors = protocol_errors + 1;
                $display("out_wr_en was high while out_full was high at t=%0t", $time);
            end
        end
    end

    task automatic compare_magnitude(input string name, input int index,
                                     input image_pkg::magnitude_t want,
                                     input image_pkg::magnitude_t got);
        if (got !== want) begin
            value_errors++;
            $display("[ERROR] t=%0t %s (result %0d): expected %02h, actual %02h",
                     $time, name, index, want, got);
        end
    endtask

    task automatic verify_result_count(input string name, input int want, input int got);
        if (got != want) begin
            count_errors++;
            $display("[ERROR] t=%0t %s: expected %0d, actual %0d", $time, name, want, got);
        end
    endtask

    task automatic load_tests();
        int i;
        $readmemh("edge_thinning_tests.txt", test_words);
        if ($isunknown(test_words[3*TOTAL-1])) begin
            file_errors++;
            $display("Test file edge_thinning_tests.txt is missing or has too few lines");
        end
        for (i = 0; i < TOTAL; i++) begin
            pixel_in[i] = test_words[3*i];
            expected[i] = test_words[3*i+1];
            stall_flag[i] = test_words[3*i+2][0];
        end
    endtask

    task automatic draw_timing();
        int i;
        for (i = 0; i < TOTAL; i++) begin
            // Roughly one pixel in four comes after a short gap
            gap_len[i] = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 3) : 0;
            if (stall_flag[i]) begin
                stall_len[i] = 3 + ($random(seed) & 3);
            end else begin
                stall_len[i] = (($random(seed) & 7) == 0) ? 1 + ($random(seed) & 1) : 0;
            end
        end
    endtask

    task automatic feed_pixels();
        int idx;
        int waited;
        idx = 0;
        while (idx < TOTAL && timeouts == 0) begin
            if (gap_len[idx] > 0) begin
                in_empty <= 1'b1;
                repeat (gap_len[idx]) @(posedge clock);
            end
            in_dout <= pixel_in[idx];
            in_empty <= 1'b0;
            waited = 0;
            do begin
                @(posedge clock);
                waited++;
            end while (!in_rd_en && waited < WAIT_LIMIT);
            if (in_rd_en) begin
                idx++;
            end else begin
                timeouts++;
                $display("Input pixel %0d was not read within %0d cycles", idx, WAIT_LIMIT);
            end
        end
        in_empty <= 1'b1;
    endtask

    task automatic collect_results();
        int idx;
        int waited;
        int frame_start;
        idx = 0;
        frame_start = 0;
        while (idx < TOTAL && timeouts == 0) begin
            // Hold the writer off so the result backs up into the buffer
            if (stall_len[idx] > 0) begin
                out_full <= 1'b1;
                repeat (stall_len[idx]) @(posedge clock);
            end
            out_full <= 1'b0;
            waited = 0;
            do begin
                @(posedge clock);
                waited++;
            end while (!out_wr_en && waited < WAIT_LIMIT);
            if (out_wr_en) begin
                compare_magnitude("out_din", idx, expected[idx], out_din);
                idx++;
                if (idx % PIXELS == 0) begin
                    verify_result_count($sformatf("results in frame %0d", idx / PIXELS - 1),
                                        PIXELS, write_count - frame_start);
                    frame_start = write_count;
                end
            end else begin
                timeouts++;
                $display("Result %0d was not written within %0d cycles", idx, WAIT_LIMIT);
            end
        end
        out_full <= 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_empty = 1'b1;
        in_dout = '0;
        out_full = 1'b0;
        seed = 32'h9736;
        value_errors = 0;
        count_errors = 0;
        protocol_errors = 0;
        timeouts = 0;
        file_errors = 0;
        write_count = 0;

        load_tests();
        draw_timing();

        repeat (8) @(posedge clock);
        reset <= 1'b0;

        if (file_errors == 0) begin
            fork
                feed_pixels();
                collect_results();
            join
            // Anything written after the last expected result is extra
            repeat (DRAIN_CYCLES) @(posedge clock);
            verify_result_count("total results", TOTAL, write_count);
        end

        $display("Errors: %0d value, %0d count, %0d protocol, %0d timeout, %0d file",
                 value_errors, count_errors, protocol_errors, timeouts, file_errors);
        if (value_errors + count_errors + protocol_errors + timeouts + file_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- edge_thinning_top.sv
// Edge-thinning top level: Sobel stage, gradient buffer and suppressor
`timescale 1ns/1ps

module edge_thinning_top (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  in_rd_en,
    input  logic                  in_empty,
    input  image_pkg::pixel_t     in_dout,
    output logic                  out_wr_en,
    input  logic                  out_full,
    output image_pkg::magnitude_t out_din
);

    // Credit link between Sobel stage and buffer
    stream_pkg::grad_link_t grad_link;
    logic                   grad_credit;

    // Buffer read port towards the suppressor
    logic                  buf_empty;
    logic                  buf_rd_en;
    image_pkg::magnitude_t buf_dout;

    sobel_gradient i_sobel (
        .clock    (clock),
        .reset    (reset),
        .in_rd_en (in_rd_en),
        .in_empty (in_empty),
        .in_dout  (in_dout),
        .link     (grad_link),
        .credit   (grad_credit)
    );

    gradient_buffer i_buffer (
        .clock  (clock),
        .reset  (reset),
        .link   (grad_link),
        .credit (grad_credit),
        .empty  (buf_empty),
        .rd_en  (buf_rd_en),
        .dout   (buf_dout)
    );

    non_maximum_suppressor i_nms (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (buf_rd_en),
        .in_empty  (buf_empty),
        .in_dout   (buf_dout),
        .out_wr_en (out_wr_en),
        .out_full  (out_full),
        .out_din   (out_din)
    );

endmodule

//--- non_maximum_suppressor.sv
// 3x3 non-maximum suppression FSM with FIFO-style read and write ports
`timescale 1ns/1ps
`include "edge_params.svh"

module non_maximum_suppressor (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  in_rd_en,
    input  logic                  in_empty,
    input  image_pkg::magnitude_t in_dout,
    output logic                  out_wr_en,
    input  logic                  out_full,
    output image_pkg::magnitude_t out_din
);

    localparam int WIDTH = `EDGE_WIDTH;
    localparam int HEIGHT = `EDGE_HEIGHT;
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int SHIFT_LEN = 2 * WIDTH + 3;

    typedef enum logic [1:0] {PROLOGUE, SUPPRESSION, OUTPUT} state_t;

    state_t state;

    image_pkg::magnitude_t shift_reg [SHIFT_LEN];
    image_pkg::magnitude_t result;

    logic [$clog2(PIXELS+1)-1:0] rd_count;
    image_pkg::position_t        pos;

    logic padding;
    logic shift_now;
    logic last_pixel;
    logic border;

    // 3x3 window taken from the line buffer
    image_pkg::magnitude_t win_nw, win_n, win_ne;
    image_pkg::magnitude_t win_w, win_c, win_e;
    image_pkg::magnitude_t win_sw, win_s, win_se;

    // Opposite-neighbour sums one bit wider than a magnitude
    logic [8:0] sum_ns, sum_ew, sum_nwse, sum_nesw;
    image_pkg::magnitude_t kept;

    always_comb begin
        padding = (rd_count == PIXELS);
        shift_now = ((state == PROLOGUE) && !in_empty) ||
                    ((state == SUPPRESSION) && (padding || !in_empty));
        in_rd_en = shift_now && !padding;
        last_pixel = (pos.row == HEIGHT - 1) && (pos.col == WIDTH - 1);
        border = (pos.row == 0) || (pos.row == HEIGHT - 1) ||
                 (pos.col == 0) || (pos.col == WIDTH - 1);
        out_wr_en = (state == OUTPUT) && !out_full;
        out_din = (state == OUTPUT) ? result : '0;
    end

    always_comb begin
        win_nw = shift_reg[0];
        win_n = shift_reg[1];
        win_ne = shift_reg[2];
        win_w = shift_reg[WIDTH];
        win_c = shift_reg[WIDTH+1];
        win_e = shift_reg[WIDTH+2];
        win_sw = shift_reg[2*WIDTH];
        win_s = shift_reg[2*WIDTH+1];
        win_se = shift_reg[2*WIDTH+2];

        sum_ns = {1'b0, win_n} + {1'b0, win_s};
        sum_ew = {1'b0, win_e} + {1'b0, win_w};
        sum_nwse = {1'b0, win_nw} + {1'b0, win_se};
        sum_nesw = {1'b0, win_ne} + {1'b0, win_sw};

        // Largest sum picks the direction and ties go to the earlier one
        kept = '0;
        if (border) begin
            kept = '0;
        end else if (sum_ns >= sum_ew && sum_ns >= sum_nwse && sum_ns >= sum_nesw) begin
            if (win_c > win_w && win_c >= win_e) begin
                kept = win_c;
            end
        end else if (sum_ew >= sum_nwse && sum_ew >= sum_nesw) begin
            if (win_c > win_n && win_c >= win_s) begin
                kept = win_c;
            end
        end else if (sum_nwse >= sum_nesw) begin
            if (win_c > win_ne && win_c >= win_sw) begin
                kept = win_c;
            end
        end else begin
            if (win_c > win_nw && win_c >= win_se) begin
                kept = win_c;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
            rd_count <= '0;
            pos <= '0;
        end else begin
            case (state)
                // Fill until pixel 0 sits at the window centre
                PROLOGUE: begin
                    if (shift_now) begin
                        rd_count <= rd_count + 1'b1;
                        if (rd_count == WIDTH + 1) begin
                            state <= SUPPRESSION;
                        end
                    end
                end
                SUPPRESSION: begin
                    if (shift_now) begin
                        if (!padding) begin
                            rd_count <= rd_count + 1'b1;
                        end
                        state <= OUTPUT;
                    end
                end
                OUTPUT: begin
                    if (!out_full) begin
                        if (last_pixel) begin
                            state <= PROLOGUE;
                            rd_count <= '0;
                            pos <= '0;
                        end else begin
                            state <= SUPPRESSION;
                            if (pos.col == WIDTH - 1) begin
                                pos.col <= '0;
                                pos.row <= pos.row + 1'b1;
                            end else begin
                                pos.col <= pos.col + 1'b1;
                            end
                        end
                    end
                end
                default: state <= PROLOGUE;
            endcase
        end
    end

    // Line buffer and result register
    always_ff @(posedge clock) begin
        if (shift_now) begin
            for (int i = 0; i < SHIFT_LEN - 1; i++) begin
                shift_reg[i] <= shift_reg[i+1];
            end
            shift_reg[SHIFT_LEN-1] <= padding ? '0 : in_dout;
        end
        if ((state == SUPPRESSION) && shift_now) begin
            result <= kept;
        end
    end

    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        out_wr_en |-> !out_full)
        else $error("non_maximum_suppressor: out_wr_en while out_full");

endmodule

//--- gradient_buffer.sv
// Circular magnitude FIFO with a credit push side and an empty/rd_en pop side
`timescale 1ns/1ps
`include "edge_params.svh"

module gradient_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  stream_pkg::grad_link_t link,
    output logic                   credit,
    output logic                   empty,
    input  logic                   rd_en,
    output image_pkg::magnitude_t  dout
);

    localparam int DEPTH = `EDGE_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    image_pkg::magnitude_t mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               push;
    logic               pop;

    // Credits guarantee room, so every push is taken
    assign push = link.valid;
    assign pop = rd_en && !empty;
    assign empty = (count == '0);
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= link.magnitude;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // Freed entry goes back to the producer next cycle
            credit <= pop;
        end
    end

    // Producer must have run out of credits before the buffer fills
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        link.valid |-> (count < DEPTH))
        else $error("gradient_buffer: push while full");

    no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !empty)
        else $error("gradient_buffer: rd_en while empty");

endmodule

//--- sobel_gradient.sv
// Line-buffered 3x3 Sobel magnitude stage with a credit-controlled output link
`timescale 1ns/1ps
`include "edge_params.svh"

module sobel_gradient (
    input  logic                   clock,
    input  logic                   reset,
    output logic                   in_rd_en,
    input  logic                   in_empty,
    input  image_pkg::pixel_t      in_dout,
    output stream_pkg::grad_link_t link,
    input  logic                   credit
);

    localparam int WIDTH = `EDGE_WIDTH;
    localparam int HEIGHT = `EDGE_HEIGHT;
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int SHIFT_LEN = 2 * WIDTH + 3;
    localparam int CREDIT_W = $clog2(`EDGE_BUF_DEPTH + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(`EDGE_BUF_DEPTH);

    // Two lines plus three pixels with the oldest at index 0
    image_pkg::pixel_t shift_reg [SHIFT_LEN];

    logic [$clog2(PIXELS+1)-1:0] rd_count;
    image_pkg::position_t        pos;
    logic [CREDIT_W-1:0]         credit_count;

    logic              padding;
    logic              step;
    logic              emit_now;
    logic              last_pixel;
    logic              border;
    image_pkg::pixel_t new_pixel;

    logic [9:0]            gx_pos, gx_neg, gy_pos, gy_neg;
    logic [9:0]            gx_abs, gy_abs;
    logic [10:0]           grad_sum;
    image_pkg::magnitude_t magnitude;

    // Frame is fully read once rd_count reaches PIXELS and zeros follow
    always_comb begin
        padding = (rd_count == PIXELS);
        step = (credit_count != '0) && (padding || !in_empty);
        in_rd_en = step && !padding;
        emit_now = step && (rd_count >= WIDTH + 2);
        new_pixel = padding ? '0 : in_dout;
        last_pixel = (pos.row == HEIGHT - 1) && (pos.col == WIDTH - 1);
        border = (pos.row == 0) || (pos.row == HEIGHT - 1) ||
                 (pos.col == 0) || (pos.col == WIDTH - 1);
    end

    // Horizontal response: right column minus left column
    always_comb begin
        gx_pos = {2'b00, shift_reg[2]} +
                 {1'b0, shift_reg[WIDTH+2], 1'b0} +
                 {2'b00, shift_reg[2*WIDTH+2]};
        gx_neg = {2'b00, shift_reg[0]} +
                 {1'b0, shift_reg[WIDTH], 1'b0} +
                 {2'b00, shift_reg[2*WIDTH]};
        // Vertical response: bottom row minus top row
        gy_pos = {2'b00, shift_reg[2*WIDTH]} +
                 {1'b0, shift_reg[2*WIDTH+1], 1'b0} +
                 {2'b00, shift_reg[2*WIDTH+2]};
        gy_neg = {2'b00, shift_reg[0]} +
                 {1'b0, shift_reg[1], 1'b0} +
                 {2'b00, shift_reg[2]};

        gx_abs = (gx_pos >= gx_neg) ? (gx_pos - gx_neg) : (gx_neg - gx_pos);
        gy_abs = (gy_pos >= gy_neg) ? (gy_pos - gy_neg) : (gy_neg - gy_pos);
        grad_sum = {1'b0, gx_abs} + {1'b0, gy_abs};

        if (border) begin
            magnitude = '0;
        end else if (grad_sum > 11'd255) begin
            magnitude = 8'hff;
        end else begin
            magnitude = grad_sum[7:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            link <= stream_pkg::GRAD_LINK_IDLE;
            rd_count <= '0;
            pos <= '0;
            credit_count <= CREDIT_INIT;
        end else begin
            link <= '{valid: emit_now, magnitude: magnitude};

            if (in_rd_en) begin
                rd_count <= rd_count + 1'b1;
            end

            // Raster position of the window centre wraps at frame end
            if (emit_now) begin
                if (pos.col == WIDTH - 1) begin
                    pos.col <= '0;
                    pos.row <= pos.row + 1'b1;
                end else begin
                    pos.col <= pos.col + 1'b1;
                end
                if (last_pixel) begin
                    pos <= '0;
                    rd_count <= '0;
                end
            end

            // One credit spent per push and one returned per buffer pop
            case ({emit_now, credit})
                2'b10: credit_count <= credit_count - 1'b1;
                2'b01: credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (step) begin
            for (int i = 0; i < SHIFT_LEN - 1; i++) begin
                shift_reg[i] <= shift_reg[i+1];
            end
            shift_reg[SHIFT_LEN-1] <= new_pixel;
        end
    end

    // Buffer may only return credits it was given
    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credit_count <= CREDIT_INIT)
        else $error("sobel_gradient: credit count above buffer depth");

endmodule

//--- stream_pkg.sv
// Credit-link word carried from the Sobel stage to the gradient buffer

package stream_pkg;

    // One push on the credit link
    // valid costs the producer one credit
    typedef struct packed {
        logic                  valid;
        image_pkg::magnitude_t magnitude;
    } grad_link_t;

    // Idle link value, driven out of reset
    localparam grad_link_t GRAD_LINK_IDLE = '{valid: 1'b0, magnitude: '0};

endpackage

//--- image_pkg.sv
// Pixel, magnitude and pixel-position types for the edge-thinning pipeline
`include "edge_params.svh"

package image_pkg;

    // Field widths of a frame position
    localparam int ROW_W = (`EDGE_HEIGHT > 1) ? $clog2(`EDGE_HEIGHT) : 1;
    localparam int COL_W = (`EDGE_WIDTH > 1) ? $clog2(`EDGE_WIDTH) : 1;

    // One grayscale input sample
    typedef logic [7:0] pixel_t;

    // Gradient magnitude saturated at 255
    typedef logic [7:0] magnitude_t;

    // Row and column of the pixel at the centre of a 3x3 window
    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } position_t;

endpackage

//--- edge_params.svh
// Frame size and gradient buffer depth macros
`ifndef EDGE_PARAMS_SVH
`define EDGE_PARAMS_SVH

// Frame size in pixels
`define EDGE_WIDTH 6
`define EDGE_HEIGHT 4

// Gradient buffer entries
// Also the number of credits the Sobel stage holds after reset
`define EDGE_BUF_DEPTH 8

`endif
